// File: rtl/core_pkg.sv
/*
 * Shared types for the single-issue scalar core with vector configuration.
 * Holds the stage, ALU, branch, memory, writeback and config enums, plus the
 * RV64 major opcode constants. Import into any module that needs them.
 */
package core_pkg;

    // ------------------------------------------------------------
    // control enums
    // ------------------------------------------------------------

    // one instruction in flight, so one stage at a time
    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_EXECUTE,
        ST_MEMORY,
        ST_WRITEBACK
    } stage_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL,
        BR_JALR
    } branch_t;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_t;

    // WB_LINK writes pc + 4, WB_CFG the vector config result
    typedef enum logic [2:0] {
        WB_NONE,
        WB_ALU,
        WB_MEM,
        WB_LINK,
        WB_CFG
    } wb_sel_t;

    typedef enum logic [1:0] {
        CFG_NONE,
        CFG_SETVL,
        CFG_READ_VLENB
    } cfg_op_t;

    // ------------------------------------------------------------
    // major opcodes
    // ------------------------------------------------------------
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [6:0] OPC_OP_V   = 7'b1010111;

endpackage

// File: rtl/instr_decoder.sv
/*
 * Combinational decoder for the supported RV64 subset plus vsetvli and
 * csrr vlenb. Unknown encodings come out as all-NONE controls, so they
 * retire as a no-op.
 */
module instr_decoder import core_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic [31:0]     instr,
    output logic [4:0]      rs1_idx,
    output logic [4:0]      rs2_idx,
    output logic [4:0]      rd_idx,
    output logic [XLEN-1:0] imm,
    output alu_op_t         alu_op,
    output logic            use_imm,
    output branch_t         branch,
    output mem_op_t         mem_op,
    output wb_sel_t         wb_sel,
    output cfg_op_t         cfg_op,
    output logic [7:0]      zimm
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign rd_idx  = instr[11:7];
    // vsetvli carries vtype in the low byte of its zimm field
    assign zimm    = instr[27:20];

    // immediate formats, sign extended
    assign imm_i = {{(XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_s = {{(XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{(XLEN-13){instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_j = {{(XLEN-21){instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        imm     = imm_i;
        alu_op  = ALU_ADD;
        use_imm = 1'b0;
        branch  = BR_NONE;
        mem_op  = MEM_NONE;
        wb_sel  = WB_NONE;
        cfg_op  = CFG_NONE;
        case (opcode)
            OPC_OP_IMM: begin
                // addi only
                if (funct3 == 3'b000) begin
                    use_imm = 1'b1;
                    wb_sel  = WB_ALU;
                end
            end
            OPC_OP: begin
                wb_sel = WB_ALU;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ALU_ADD;
                    10'b0100000_000: alu_op = ALU_SUB;
                    10'b0000000_111: alu_op = ALU_AND;
                    10'b0000000_110: alu_op = ALU_OR;
                    10'b0000000_100: alu_op = ALU_XOR;
                    10'b0000000_010: alu_op = ALU_SLT;
                    default:         wb_sel = WB_NONE;
                endcase
            end
            OPC_LOAD: begin
                // ld, address from rs1 + imm
                if (funct3 == 3'b011) begin
                    use_imm = 1'b1;
                    mem_op  = MEM_LOAD;
                    wb_sel  = WB_MEM;
                end
            end
            OPC_STORE: begin
                if (funct3 == 3'b011) begin
                    imm     = imm_s;
                    use_imm = 1'b1;
                    mem_op  = MEM_STORE;
                end
            end
            OPC_BRANCH: begin
                // compare by subtraction, zero flag decides
                imm    = imm_b;
                alu_op = ALU_SUB;
                if (funct3 == 3'b000) begin
                    branch = BR_EQ;
                end else if (funct3 == 3'b001) begin
                    branch = BR_NE;
                end
            end
            OPC_JAL: begin
                imm    = imm_j;
                branch = BR_JAL;
                wb_sel = WB_LINK;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    use_imm = 1'b1;
                    branch  = BR_JALR;
                    wb_sel  = WB_LINK;
                end
            end
            OPC_SYSTEM: begin
                // csrrs on vlenb (0xc22) is the only csr read kept
                if (funct3 == 3'b010 && instr[31:20] == 12'hc22) begin
                    cfg_op = CFG_READ_VLENB;
                    wb_sel = WB_CFG;
                end
            end
            OPC_OP_V: begin
                if (funct3 == 3'b111 && !instr[31]) begin
                    cfg_op = CFG_SETVL;
                    wb_sel = WB_CFG;
                end
            end
            default: begin
                wb_sel = WB_NONE;
            end
        endcase
    end

endmodule

// File: rtl/scalar_alu.sv
/*
 * Scalar ALU for the core. Pure combinational; the zero flag lets the
 * branch logic resolve beq/bne from an ALU_SUB result.
 */
module scalar_alu import core_pkg::*; #(
    parameter int XLEN = 64
) (
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    input  alu_op_t         alu_op,
    output logic [XLEN-1:0] result,
    output logic            zero
);

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                // signed compare
                result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            default: begin
                result = a + b;
            end
        endcase
    end

    assign zero = (result == '0);

endmodule

// File: rtl/scalar_reg_file.sv
/*
 * 32-entry scalar register file. Two combinational read ports, one write
 * port at the clock edge. x0 ignores writes and reads as zero.
 */
module scalar_reg_file #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic [4:0]      rs1_idx,
    input  logic [4:0]      rs2_idx,
    input  logic            we,
    input  logic [4:0]      rd_idx,
    input  logic [XLEN-1:0] rd_data,
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_idx != 5'd0) begin
            regs[rd_idx] <= rd_data;
        end
    end

    assign rs1_data = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

// File: rtl/vector_config.sv
/*
 * Vector configuration state: vl and vtype. Executes vsetvli and supplies
 * the read-only vlenb value. The result is combinational and the state
 * updates at the clock edge while cfg_op is CFG_SETVL.
 */
module vector_config import core_pkg::*; #(
    parameter int VLEN_BITS = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  cfg_op_t     cfg_op,
    input  logic [4:0]  rs1_idx,
    input  logic [4:0]  rd_idx,
    input  logic [63:0] avl,
    input  logic [7:0]  zimm,
    output logic [63:0] cfg_result
);

    localparam logic [31:0] VLENB = 32'(VLEN_BITS / 8);

    logic [31:0] vl;
    logic [7:0]  vtype;
    logic [2:0]  vsew;
    logic [2:0]  vlmul;
    logic [31:0] vlmax;
    logic [31:0] new_vl;

    assign vsew  = zimm[5:3];
    assign vlmul = zimm[2:0];

    // vlmax from the requested type, fractional lmul for codes 5..7
    always_comb begin
        if (!vlmul[2]) begin
            vlmax = (VLENB >> vsew) << vlmul;
        end else begin
            vlmax = (VLENB >> vsew) >> (4'd8 - {1'b0, vlmul});
        end
    end

    // avl taken as is when rs1 names a register, no clamp to vlmax
    always_comb begin
        if (rs1_idx != 5'd0) begin
            new_vl = avl[31:0];
        end else if (rd_idx != 5'd0) begin
            new_vl = vlmax;
        end else begin
            new_vl = vl;
        end
    end

    always_comb begin
        case (cfg_op)
            CFG_SETVL:      cfg_result = {32'd0, new_vl};
            CFG_READ_VLENB: cfg_result = {32'd0, VLENB};
            // idle view of the current configuration
            default:        cfg_result = {24'd0, vtype, vl};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vl    <= '0;
            vtype <= '0;
        end else if (cfg_op == CFG_SETVL) begin
            vl    <= new_vl;
            vtype <= zimm;
        end
    end

endmodule

// File: rtl/vector_core.sv
/*
 * Top of the in-order core. One instruction moves through fetch, decode,
 * execute, memory and writeback before the next is fetched. Instruction and
 * data ports use request levels answered by one-cycle valid/done pulses.
 */
module vector_core import core_pkg::*; #(
    parameter int XLEN       = 64,
    parameter int VLEN_BITS  = 256,
    parameter int ADDR_WIDTH = 20
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid,
    input  logic [31:0]           inst_data,
    input  logic [XLEN-1:0]       data_rdata,
    input  logic                  data_done,
    output logic                  inst_req,
    output logic [ADDR_WIDTH-1:0] inst_addr,
    output logic                  data_req,
    output logic                  data_we,
    output logic [ADDR_WIDTH-1:0] data_addr,
    output logic [XLEN-1:0]       data_wdata
);

    stage_t                stage;
    logic                  running;
    logic [ADDR_WIDTH-1:0] pc;
    logic [ADDR_WIDTH-1:0] next_pc;

    // fetch stage register
    logic [31:0]     fetch_instr;

    // decoder outputs and decode stage registers
    logic [4:0]      id_rs1_idx, id_rs2_idx, id_rd_idx;
    logic [XLEN-1:0] id_imm;
    alu_op_t         id_alu_op;
    logic            id_use_imm;
    branch_t         id_branch;
    mem_op_t         id_mem_op;
    wb_sel_t         id_wb_sel;
    cfg_op_t         id_cfg_op;
    logic [7:0]      id_zimm;
    logic [XLEN-1:0] rf_rs1_data, rf_rs2_data;

    logic [XLEN-1:0] dec_rs1_data, dec_rs2_data, dec_imm;
    logic [4:0]      dec_rs1_idx, dec_rd_idx;
    alu_op_t         dec_alu_op;
    logic            dec_use_imm;
    branch_t         dec_branch;
    mem_op_t         dec_mem_op;
    wb_sel_t         dec_wb_sel;
    cfg_op_t         dec_cfg_op;
    logic [7:0]      dec_zimm;

    // execute stage registers and load data
    logic [XLEN-1:0] alu_result;
    logic            alu_zero;
    cfg_op_t         cfg_op;
    logic [63:0]     cfg_result;
    logic [XLEN-1:0] exe_result, exe_cfg_result, mem_rdata;
    logic            exe_zero;

    logic            rf_we;
    logic [XLEN-1:0] rf_wdata;
    logic            taken;

    instr_decoder #(.XLEN(XLEN)) u_decoder (
        .instr(fetch_instr), .rs1_idx(id_rs1_idx), .rs2_idx(id_rs2_idx),
        .rd_idx(id_rd_idx), .imm(id_imm), .alu_op(id_alu_op), .use_imm(id_use_imm),
        .branch(id_branch), .mem_op(id_mem_op), .wb_sel(id_wb_sel),
        .cfg_op(id_cfg_op), .zimm(id_zimm)
    );

    scalar_reg_file #(.XLEN(XLEN)) u_reg_file (
        .clk(clk), .rst(rst), .rs1_idx(id_rs1_idx), .rs2_idx(id_rs2_idx),
        .we(rf_we), .rd_idx(dec_rd_idx), .rd_data(rf_wdata),
        .rs1_data(rf_rs1_data), .rs2_data(rf_rs2_data)
    );

    scalar_alu #(.XLEN(XLEN)) u_alu (
        .a(dec_rs1_data), .b(dec_use_imm ? dec_imm : dec_rs2_data),
        .alu_op(dec_alu_op), .result(alu_result), .zero(alu_zero)
    );

    // config state only changes in the execute cycle
    assign cfg_op = (stage == ST_EXECUTE) ? dec_cfg_op : CFG_NONE;

    vector_config #(.VLEN_BITS(VLEN_BITS)) u_vector_config (
        .clk(clk), .rst(rst), .cfg_op(cfg_op), .rs1_idx(dec_rs1_idx),
        .rd_idx(dec_rd_idx), .avl(64'(dec_rs1_data)), .zimm(dec_zimm),
        .cfg_result(cfg_result)
    );

    // ------------------------------------------------------------
    // memory ports
    // ------------------------------------------------------------
    assign inst_req   = running && stage == ST_FETCH;
    assign inst_addr  = pc;
    assign data_req   = (stage == ST_MEMORY);
    assign data_we    = (dec_mem_op == MEM_STORE);
    assign data_addr  = exe_result[ADDR_WIDTH-1:0];
    assign data_wdata = dec_rs2_data;

    // ------------------------------------------------------------
    // next pc, from the latched execute results
    // ------------------------------------------------------------
    assign taken = (dec_branch == BR_JAL)
                || (dec_branch == BR_EQ && exe_zero)
                || (dec_branch == BR_NE && !exe_zero);

    always_comb begin
        if (dec_branch == BR_JALR) begin
            next_pc = exe_result[ADDR_WIDTH-1:0] & ~ADDR_WIDTH'(1);
        end else if (taken) begin
            next_pc = pc + dec_imm[ADDR_WIDTH-1:0];
        end else begin
            next_pc = pc + ADDR_WIDTH'(4);
        end
    end

    // writeback select
    assign rf_we = (stage == ST_WRITEBACK) && (dec_wb_sel != WB_NONE);
    always_comb begin
        case (dec_wb_sel)
            WB_MEM:  rf_wdata = mem_rdata;
            WB_LINK: rf_wdata = XLEN'(pc) + XLEN'(4);
            WB_CFG:  rf_wdata = exe_cfg_result;
            default: rf_wdata = exe_result;
        endcase
    end

    // ------------------------------------------------------------
    // stage machine
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst) begin
            stage   <= ST_FETCH;
            running <= 1'b0;
            pc      <= '0;
        end else begin
            running <= 1'b1;
            case (stage)
                ST_FETCH: begin
                    if (inst_valid) stage <= ST_DECODE;
                end
                ST_DECODE: begin
                    stage <= ST_EXECUTE;
                end
                ST_EXECUTE: begin
                    stage <= (dec_mem_op == MEM_NONE) ? ST_WRITEBACK : ST_MEMORY;
                end
                ST_MEMORY: begin
                    if (data_done) begin
                        pc    <= next_pc;
                        stage <= ST_WRITEBACK;
                    end
                end
                default: begin
                    // the memory slot was skipped, so the pc moves here
                    if (dec_mem_op == MEM_NONE) pc <= next_pc;
                    stage <= ST_FETCH;
                end
            endcase
        end
    end

    // stage payload registers
    always_ff @(posedge clk) begin
        if (stage == ST_FETCH && inst_valid) begin
            fetch_instr <= inst_data;
        end
        if (stage == ST_DECODE) begin
            dec_rs1_data <= rf_rs1_data;
            dec_rs2_data <= rf_rs2_data;
            dec_imm      <= id_imm;
            dec_rs1_idx  <= id_rs1_idx;
            dec_rd_idx   <= id_rd_idx;
            dec_alu_op   <= id_alu_op;
            dec_use_imm  <= id_use_imm;
            dec_branch   <= id_branch;
            dec_mem_op   <= id_mem_op;
            dec_wb_sel   <= id_wb_sel;
            dec_cfg_op   <= id_cfg_op;
            dec_zimm     <= id_zimm;
        end
        if (stage == ST_EXECUTE) begin
            exe_result     <= alu_result;
            exe_zero       <= alu_zero;
            exe_cfg_result <= XLEN'(cfg_result);
        end
        if (stage == ST_MEMORY && data_done) begin
            mem_rdata <= data_rdata;
        end
    end

endmodule

// File: verification/core_mem_model.sv
/*
 * Instruction ROM and data RAM for the core testbench. Each request is
 * answered by a one-cycle pulse after 1 to 4 cycles picked with $random.
 * The testbench writes the program into rom before reset is released.
 */
module core_mem_model #(
    parameter int XLEN       = 64,
    parameter int ADDR_WIDTH = 20,
    parameter int ROM_BITS   = 8,
    parameter int RAM_BITS   = 8
) (
    input  logic                  clk,
    input  logic                  inst_req,
    input  logic [ADDR_WIDTH-1:0] inst_addr,
    output logic                  inst_valid,
    output logic [31:0]           inst_data,
    input  logic                  data_req,
    input  logic                  data_we,
    input  logic [ADDR_WIDTH-1:0] data_addr,
    input  logic [XLEN-1:0]       data_wdata,
    output logic [XLEN-1:0]       data_rdata,
    output logic                  data_done
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0]     rom [2**ROM_BITS];
    logic [XLEN-1:0] ram [2**RAM_BITS];

    integer seed = 97836;
    // cycles left before the answer, -1 when idle
    int inst_wait = -1;
    int data_wait = -1;

    function automatic int pick_delay();
        return int'($unsigned($random(seed)) % 4);
    endfunction

    initial begin
        inst_valid = 1'b0;
        inst_data  = '0;
        data_done  = 1'b0;
        data_rdata = '0;
        // addi x0, x0, index keeps unused rom words harmless
        for (int i = 0; i < 2**ROM_BITS; i++) begin
            rom[i[ROM_BITS-1:0]] = {i[11:0], 20'h00013};
        end
        for (int i = 0; i < 2**RAM_BITS; i++) begin
            ram[i[RAM_BITS-1:0]] = XLEN'({32'h5a5a_0000 ^ i, i << 3});
        end
    end

    // answers change on the falling edge, the core samples on the rising one
    always @(negedge clk) begin
        if (inst_valid) begin
            inst_valid = 1'b0;
        end else if (inst_req) begin
            if (inst_wait < 0) begin
                inst_wait = pick_delay();
            end
            if (inst_wait == 0) begin
                inst_data  = rom[inst_addr[ROM_BITS+1:2]];
                inst_valid = 1'b1;
                inst_wait  = -1;
            end else begin
                inst_wait--;
            end
        end
    end

    always @(negedge clk) begin
        if (data_done) begin
            data_done = 1'b0;
        end else if (data_req) begin
            if (data_wait < 0) begin
                data_wait = pick_delay();
            end
            if (data_wait == 0) begin
                if (data_we) begin
                    ram[data_addr[RAM_BITS+2:3]] = data_wdata;
                end else begin
                    data_rdata = ram[data_addr[RAM_BITS+2:3]];
                end
                data_done = 1'b1;
                data_wait = -1;
            end else begin
                data_wait--;
            end
        end
    end

endmodule

// File: verification/core_tb.sv
/*
 * Testbench for vector_core. Builds a small RV64 program into the memory
 * model, then checks every store, the fetch addresses and the stage timing
 * with assertions sampled on the rising clock edge.
 */
module core_tb import core_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int XLEN       = 64;
    localparam int VLEN_BITS  = 256;
    localparam int ADDR_WIDTH = 20;
    localparam int BASE       = 'h400;

    // worst case per instruction is 4 stage cycles plus two 4-cycle waits
    localparam int WATCHDOG_NS = 40 * (4 + 2 * 4) * 8 + 16 * 8;

    localparam int T_RESET  = 0;
    localparam int T_ARITH  = 1;
    localparam int T_LDST   = 2;
    localparam int T_CTRL   = 3;
    localparam int T_VCFG   = 4;
    localparam int T_TIMING = 5;

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  inst_req;
    logic [ADDR_WIDTH-1:0] inst_addr;
    logic                  inst_valid;
    logic [31:0]           inst_data;
    logic                  data_req;
    logic                  data_we;
    logic [ADDR_WIDTH-1:0] data_addr;
    logic [XLEN-1:0]       data_wdata;
    logic [XLEN-1:0]       data_rdata;
    logic                  data_done;

    string test_name [$] = '{"reset", "arithmetic", "load/store", "control flow",
                             "vector config", "stage timing"};
    int    errs [$]      = '{0, 0, 0, 0, 0, 0};

    // expected stores in program order
    logic [ADDR_WIDTH-1:0] exp_addr [$];
    logic [63:0]           exp_data [$];
    int                    exp_test [$];
    int                    n_exp = 0;
    int                    store_idx = 0;

    logic [ADDR_WIDTH-1:0] skip_addr [$];
    int                    pc_idx = 0;
    int                    reset_cycles = 0;
    int                    timing_due = 0;
    bit                    fetch_seen = 1'b0;

    always #4 clk = ~clk;

    vector_core #(
        .XLEN(XLEN), .VLEN_BITS(VLEN_BITS), .ADDR_WIDTH(ADDR_WIDTH)
    ) dut (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst_data(inst_data),
        .data_rdata(data_rdata), .data_done(data_done), .inst_req(inst_req),
        .inst_addr(inst_addr), .data_req(data_req), .data_we(data_we),
        .data_addr(data_addr), .data_wdata(data_wdata)
    );

    core_mem_model #(.XLEN(XLEN), .ADDR_WIDTH(ADDR_WIDTH)) mem (
        .clk(clk), .inst_req(inst_req), .inst_addr(inst_addr),
        .inst_valid(inst_valid), .inst_data(inst_data), .data_req(data_req),
        .data_we(data_we), .data_addr(data_addr), .data_wdata(data_wdata),
        .data_rdata(data_rdata), .data_done(data_done)
    );

    // ----------------------------------------------------------
    // instruction encoding
    // ----------------------------------------------------------
    function automatic logic [31:0] i_type(logic [6:0] opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] r_type(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
    endfunction

    // sd only
    function automatic logic [31:0] s_type(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OPC_JAL};
    endfunction

    function automatic logic is_mem_instr(logic [31:0] word);
        return (word[6:0] == OPC_LOAD || word[6:0] == OPC_STORE) && word[14:12] == 3'b011;
    endfunction

    task automatic emit(input logic [31:0] word);
        mem.rom[pc_idx[7:0]] = word;
        pc_idx++;
    endtask

    // an instruction that must never be fetched
    task automatic emit_skipped(input logic [31:0] word);
        skip_addr.push_back(ADDR_WIDTH'(pc_idx * 4));
        emit(word);
    endtask

    // sd rs2 to BASE + offset and queue the value it must carry
    task automatic store_and_expect(input int test, input int rs2, input int offset,
                                    input logic [63:0] value);
        emit(s_type(rs2, 10, offset));
        exp_addr.push_back(ADDR_WIDTH'(BASE + offset));
        exp_data.push_back(value);
        exp_test.push_back(test);
        n_exp++;
    endtask

    task automatic build_program();
        logic signed [63:0] a;
        logic signed [63:0] b;
        int jal_pc;
        int target;
        a = 64'sd100;
        b = -64'sd7;
        emit(i_type(OPC_OP_IMM, 0, 10, 0, BASE));
        emit(i_type(OPC_OP_IMM, 0, 1, 0, 100));
        emit(i_type(OPC_OP_IMM, 0, 2, 0, -7));
        store_and_expect(T_ARITH, 1, 0, a);
        emit(r_type(0, 0, 3, 1, 2));
        store_and_expect(T_ARITH, 3, 8, a + b);
        emit(r_type('h20, 0, 4, 1, 2));
        store_and_expect(T_ARITH, 4, 16, a - b);
        emit(r_type(0, 7, 5, 1, 2));
        store_and_expect(T_ARITH, 5, 24, a & b);
        emit(r_type(0, 6, 6, 1, 2));
        store_and_expect(T_ARITH, 6, 32, a | b);
        emit(r_type(0, 4, 7, 1, 2));
        store_and_expect(T_ARITH, 7, 40, a ^ b);
        // slt both ways round with the negative operand
        emit(r_type(0, 2, 8, 2, 1));
        store_and_expect(T_ARITH, 8, 48, (b < a) ? 64'd1 : 64'd0);
        emit(r_type(0, 2, 9, 1, 2));
        store_and_expect(T_ARITH, 9, 56, (a < b) ? 64'd1 : 64'd0);
        emit(i_type(OPC_OP_IMM, 0, 11, 1, -200));
        store_and_expect(T_ARITH, 11, 64, a - 64'sd200);

        // store, load back, store the loaded value
        store_and_expect(T_LDST, 2, 72, b);
        emit(i_type(OPC_LOAD, 3, 13, 10, 72));
        store_and_expect(T_LDST, 13, 80, b);

        // ------------------------------------------------------
        // control flow
        // ------------------------------------------------------
        emit(b_type(0, 1, 1, 8));
        emit_skipped(i_type(OPC_OP_IMM, 0, 14, 0, 1));
        emit(b_type(1, 1, 1, 8));
        emit(i_type(OPC_OP_IMM, 0, 15, 0, 5));
        store_and_expect(T_CTRL, 15, 88, 64'd5);
        jal_pc = pc_idx * 4;
        emit(j_type(16, 8));
        emit_skipped(i_type(OPC_OP_IMM, 0, 14, 0, 2));
        store_and_expect(T_CTRL, 16, 96, 64'(jal_pc + 4));
        // jalr target built with bit 0 set, one word skipped before it
        target = (pc_idx + 3) * 4;
        emit(i_type(OPC_OP_IMM, 0, 17, 0, target + 1));
        emit(i_type(OPC_JALR, 0, 0, 17, 0));
        emit_skipped(i_type(OPC_OP_IMM, 0, 14, 0, 3));
        store_and_expect(T_CTRL, 14, 104, 64'd0);

        // vsetvli vtype byte is {vsew, vlmul}
        emit(i_type(OPC_OP_IMM, 0, 5, 0, 100));
        emit(i_type(OPC_OP_V, 7, 19, 5, 'h00));
        store_and_expect(T_VCFG, 19, 112, 64'd100);
        emit(i_type(OPC_OP_V, 7, 20, 0, 'h11));
        // e32 divides vlenb by 4, m2 doubles it
        store_and_expect(T_VCFG, 20, 120, 64'((VLEN_BITS / 8 >> 2) << 1));
        emit(i_type(OPC_SYSTEM, 2, 21, 0, 'hc22));
        store_and_expect(T_VCFG, 21, 128, 64'(VLEN_BITS / 8));
        emit(j_type(0, 0));
    endtask

    // ----------------------------------------------------------
    // reporting
    // ----------------------------------------------------------
    task automatic report_mismatch(input int test, input string sig,
                                   input logic [63:0] expected, input logic [63:0] actual);
        $display("FAIL %s expected %h actual %h in %s test", sig, expected, actual,
                 test_name[test]);
        errs[test]++;
    endtask

    task automatic report_problem(input int test, input string what);
        $display("error in %s test: %s", test_name[test], what);
        errs[test]++;
    endtask

    task automatic finish_test(input int test);
        $display("test %s finished with %0d error(s)", test_name[test], errs[test]);
    endtask

    task automatic check_store();
        int t;
        if (store_idx >= n_exp) begin
            report_problem(T_LDST, "store seen after the last expected one");
        end else begin
            t = exp_test[store_idx];
            assert (data_addr == exp_addr[store_idx]) else begin
                report_mismatch(t, "data_addr", 64'(exp_addr[store_idx]), 64'(data_addr));
            end
            assert (data_wdata == exp_data[store_idx]) else begin
                report_mismatch(t, "data_wdata", exp_data[store_idx], data_wdata);
            end
            if (store_idx == n_exp - 1 || exp_test[store_idx + 1] != t) begin
                finish_test(t);
            end
            store_idx++;
        end
    endtask

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    always @(posedge clk) begin
        if (!rst) begin
            // core state is unknown until the first reset edge
            if (reset_cycles > 0) begin
                assert (!inst_req && !data_req) else begin
                    report_problem(T_RESET, "request raised while reset was asserted");
                end
            end
            reset_cycles++;
        end else begin
            if (inst_req && !fetch_seen) begin
                fetch_seen = 1'b1;
                assert (inst_addr == '0) else begin
                    report_mismatch(T_RESET, "inst_addr", 64'd0, 64'(inst_addr));
                end
                finish_test(T_RESET);
            end
            assert (!(inst_req && data_req)) else begin
                report_problem(T_LDST, "inst_req and data_req were high in the same cycle");
            end
            if (inst_req && inst_valid) begin
                // jalr must clear bit 0, the rom alone would hide it
                assert (inst_addr[1:0] == 2'b00) else begin
                    report_mismatch(T_CTRL, "inst_addr[1:0]", 64'd0, 64'(inst_addr[1:0]));
                end
                foreach (skip_addr[i]) begin
                    assert (inst_addr != skip_addr[i]) else begin
                        report_problem(T_CTRL, $sformatf("fetch from skipped address %h",
                                                         inst_addr));
                    end
                end
            end
            // inst_req stays low until the due cycle, then must be high
            if (timing_due > 0) begin
                timing_due--;
                if (timing_due == 0) begin
                    assert (inst_req) else begin
                        report_problem(T_TIMING, "inst_req did not rise on time");
                    end
                end else begin
                    assert (!inst_req) else begin
                        report_problem(T_TIMING, "inst_req rose too early");
                    end
                end
            end
            if (inst_req && inst_valid && !is_mem_instr(inst_data)) begin
                timing_due = 4;
            end
            if (data_done) begin
                timing_due = 2;
            end
            if (data_req && data_we && data_done) begin
                check_store();
            end
        end
    end

    initial begin
        int total;
        int failed;
        rst = 1'b0;
        @(negedge clk);
        build_program();
        // 16 rising edges in reset, counting the first one
        repeat (15) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        wait (store_idx == n_exp);
        // the last store's timing check lands on the next fetch
        do begin
            @(posedge clk);
        end while (!inst_req);
        @(negedge clk);
        finish_test(T_TIMING);

        total = 0;
        failed = 0;
        foreach (errs[i]) begin
            total += errs[i];
            if (errs[i] > 0) begin
                failed++;
            end
        end
        $display("tests run: %0d, failed: %0d, errors: %0d", errs.size(), failed, total);
        if (total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired with the core stuck in stage %s", dut.stage.name());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb.f
rtl/core_pkg.sv
rtl/instr_decoder.sv
rtl/scalar_alu.sv
rtl/scalar_reg_file.sv
rtl/vector_config.sv
rtl/vector_core.sv
verification/core_mem_model.sv
verification/core_tb.sv

// File: run.sh
#!/bin/sh
# builds the core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module core_tb -Mdir obj_dir -f tb.f; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vcore_tb > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1
